// ==== mcpu_pkg.sv ====
`default_nettype none

package mcpu_pkg;

  // Datapath widths
  typedef logic [31:0] mcpu_word_t;
  typedef logic [4:0]  mcpu_reg_idx_t;
  typedef logic [3:0]  mcpu_opcode_t;
  typedef logic [2:0]  mcpu_compare_type_t;
  typedef logic [1:0]  mcpu_shift_type_t;

  // Bit 5 set means 32 or more
  typedef logic [5:0]  mcpu_shift_amount_t;

  // Execute opcodes, 12 to 15 are invalid
  localparam mcpu_opcode_t OP_ADD = 4'd0;
  localparam mcpu_opcode_t OP_AND = 4'd1;
  localparam mcpu_opcode_t OP_NOR = 4'd2;
  localparam mcpu_opcode_t OP_OR  = 4'd3;
  // Second operand minus first
  localparam mcpu_opcode_t OP_RSB = 4'd4;
  localparam mcpu_opcode_t OP_SUB = 4'd5;
  localparam mcpu_opcode_t OP_XOR = 4'd6;
  localparam mcpu_opcode_t OP_CMP = 4'd7;
  localparam mcpu_opcode_t OP_MOV = 4'd8;
  localparam mcpu_opcode_t OP_MVN = 4'd9;
  localparam mcpu_opcode_t OP_SXB = 4'd10;
  localparam mcpu_opcode_t OP_SXH = 4'd11;

  // Compare kinds, result lands in bit 0
  localparam mcpu_compare_type_t CMP_LTU    = 3'd0;
  localparam mcpu_compare_type_t CMP_LEU    = 3'd1;
  localparam mcpu_compare_type_t CMP_EQ     = 3'd2;
  localparam mcpu_compare_type_t CMP_BAD    = 3'd3;
  localparam mcpu_compare_type_t CMP_LTS    = 3'd4;
  localparam mcpu_compare_type_t CMP_LES    = 3'd5;
  localparam mcpu_compare_type_t CMP_TST    = 3'd6;
  localparam mcpu_compare_type_t CMP_SUBSET = 3'd7;

  // Shift kinds
  localparam mcpu_shift_type_t SH_LSL = 2'd0;
  localparam mcpu_shift_type_t SH_LSR = 2'd1;
  localparam mcpu_shift_type_t SH_ASR = 2'd2;
  localparam mcpu_shift_type_t SH_ROR = 2'd3;

endpackage

`default_nettype wire

// ==== mcpu_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_shifter (
  input  mcpu_pkg::mcpu_word_t         sop,
  input  mcpu_pkg::mcpu_shift_type_t   shift_type,
  input  mcpu_pkg::mcpu_shift_amount_t shift_amount,
  output mcpu_pkg::mcpu_word_t         shifted_op2
);

  import mcpu_pkg::*;

  logic [4:0]  amt;
  logic        big_shift;
  logic [63:0] rot_wide;

  assign amt = shift_amount[4:0];

  // Rotate ignores bit 5 of the amount
  assign big_shift = shift_amount[5] && (shift_type != SH_ROR);

  // Low half of the doubled word is the rotated value, also for amount 0
  assign rot_wide = {sop, sop} >> amt;

  always_comb begin
    if (big_shift) begin
      if (shift_type == SH_ASR) begin
        shifted_op2 = {32{sop[31]}};
      end else begin
        shifted_op2 = '0;
      end
    end else begin
      case (shift_type)
        SH_LSL:  shifted_op2 = sop << amt;
        SH_LSR:  shifted_op2 = sop >> amt;
        SH_ASR:  shifted_op2 = $signed(sop) >>> amt;
        default: shifted_op2 = rot_wide[31:0];
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== mcpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_alu (
  input  mcpu_pkg::mcpu_word_t         rt_data,
  input  mcpu_pkg::mcpu_word_t         sop,
  input  mcpu_pkg::mcpu_opcode_t       opcode,
  input  mcpu_pkg::mcpu_compare_type_t compare_type,
  input  mcpu_pkg::mcpu_shift_type_t   shift_type,
  input  mcpu_pkg::mcpu_shift_amount_t shift_amount,
  output mcpu_pkg::mcpu_word_t         result,
  output logic                         alu_invalid
);

  import mcpu_pkg::*;

  mcpu_word_t shifted_op2;
  logic       cmp_bit;

  mcpu_shifter u_shifter (
    .sop          (sop),
    .shift_type   (shift_type),
    .shift_amount (shift_amount),
    .shifted_op2  (shifted_op2)
  );

  // Compare outcome, always against the shifted operand
  always_comb begin
    cmp_bit = 1'b0;
    case (compare_type)
      CMP_LTU:    cmp_bit = rt_data < shifted_op2;
      CMP_LEU:    cmp_bit = rt_data <= shifted_op2;
      CMP_EQ:     cmp_bit = rt_data == shifted_op2;
      CMP_LTS:    cmp_bit = $signed(rt_data) < $signed(shifted_op2);
      CMP_LES:    cmp_bit = $signed(rt_data) <= $signed(shifted_op2);
      CMP_TST:    cmp_bit = |(rt_data & shifted_op2);
      CMP_SUBSET: cmp_bit = ~|(~rt_data & shifted_op2);
      default:    cmp_bit = 1'b0;
    endcase
  end

  // Invalid cases leave the result at zero
  always_comb begin
    result      = '0;
    alu_invalid = 1'b0;
    case (opcode)
      OP_ADD: result = rt_data + shifted_op2;
      OP_AND: result = rt_data & shifted_op2;
      OP_NOR: result = ~(rt_data | shifted_op2);
      OP_OR:  result = rt_data | shifted_op2;
      OP_RSB: result = shifted_op2 - rt_data;
      OP_SUB: result = rt_data - shifted_op2;
      OP_XOR: result = rt_data ^ shifted_op2;
      OP_MOV: result = shifted_op2;
      OP_MVN: result = ~shifted_op2;
      OP_SXB: result = {{24{shifted_op2[7]}}, shifted_op2[7:0]};
      OP_SXH: result = {{16{shifted_op2[15]}}, shifted_op2[15:0]};
      OP_CMP: begin
        if (compare_type == CMP_BAD) begin
          alu_invalid = 1'b1;
        end else begin
          result = {31'b0, cmp_bit};
        end
      end
      default: begin
        alu_invalid = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== mcpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                    clkrst_core_clk,
  input  logic                    reset,
  input  mcpu_pkg::mcpu_reg_idx_t rt_idx,
  input  mcpu_pkg::mcpu_reg_idx_t rs_idx,
  output mcpu_pkg::mcpu_word_t    rt_data,
  output mcpu_pkg::mcpu_word_t    rs_data,
  input  logic                    we,
  input  mcpu_pkg::mcpu_reg_idx_t wr_idx,
  input  mcpu_pkg::mcpu_word_t    wr_data
);

  import mcpu_pkg::*;

  mcpu_word_t regs [NUM_REGS];

  // Register 0 and indices past the file are not backed by storage
  function automatic logic idx_live(input mcpu_reg_idx_t idx);
    return (idx != '0) && (int'(idx) < NUM_REGS);
  endfunction

  assign rt_data = idx_live(rt_idx) ? regs[rt_idx] : '0;
  assign rs_data = idx_live(rs_idx) ? regs[rs_idx] : '0;

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && idx_live(wr_idx)) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== mcpu_exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_exec_stage #(
  parameter int NUM_REGS = 32
) (
  input  logic                         clkrst_core_clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  mcpu_pkg::mcpu_reg_idx_t      in_rt_idx,
  input  mcpu_pkg::mcpu_reg_idx_t      in_rs_idx,
  input  mcpu_pkg::mcpu_reg_idx_t      in_rd_idx,
  input  logic                         in_use_imm,
  input  mcpu_pkg::mcpu_word_t         in_imm,
  input  mcpu_pkg::mcpu_opcode_t       in_opcode,
  input  mcpu_pkg::mcpu_compare_type_t in_compare_type,
  input  mcpu_pkg::mcpu_shift_type_t   in_shift_type,
  input  mcpu_pkg::mcpu_shift_amount_t in_shift_amount,
  output mcpu_pkg::mcpu_reg_idx_t      rf_rt_idx,
  output mcpu_pkg::mcpu_reg_idx_t      rf_rs_idx,
  input  mcpu_pkg::mcpu_word_t         rf_rt_data,
  input  mcpu_pkg::mcpu_word_t         rf_rs_data,
  output logic                         rf_we,
  output mcpu_pkg::mcpu_reg_idx_t      rf_wr_idx,
  output mcpu_pkg::mcpu_word_t         rf_wr_data,
  output logic                         wb_valid,
  output mcpu_pkg::mcpu_reg_idx_t      wb_rd_idx,
  output mcpu_pkg::mcpu_word_t         wb_result,
  output logic                         wb_invalid
);

  import mcpu_pkg::*;

  // Issue register
  logic               iss_valid;
  mcpu_reg_idx_t      iss_rt_idx;
  mcpu_reg_idx_t      iss_rs_idx;
  mcpu_reg_idx_t      iss_rd_idx;
  logic               iss_use_imm;
  mcpu_word_t         iss_imm;
  mcpu_opcode_t       iss_opcode;
  mcpu_compare_type_t iss_compare_type;
  mcpu_shift_type_t   iss_shift_type;
  mcpu_shift_amount_t iss_shift_amount;

  logic       byp_ok;
  mcpu_word_t rt_data;
  mcpu_word_t rs_data;
  mcpu_word_t sop;
  mcpu_word_t alu_result;
  logic       alu_invalid;

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= in_valid;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (in_valid) begin
      iss_rt_idx       <= in_rt_idx;
      iss_rs_idx       <= in_rs_idx;
      iss_rd_idx       <= in_rd_idx;
      iss_use_imm      <= in_use_imm;
      iss_imm          <= in_imm;
      iss_opcode       <= in_opcode;
      iss_compare_type <= in_compare_type;
      iss_shift_type   <= in_shift_type;
      iss_shift_amount <= in_shift_amount;
    end
  end

  assign rf_rt_idx = iss_rt_idx;
  assign rf_rs_idx = iss_rs_idx;

  // Result still in the writeback register, not yet in the file
  assign byp_ok = rf_we && (wb_rd_idx != '0) && (int'(wb_rd_idx) < NUM_REGS);

  assign rt_data = (byp_ok && (iss_rt_idx == wb_rd_idx)) ? wb_result : rf_rt_data;
  assign rs_data = (byp_ok && (iss_rs_idx == wb_rd_idx)) ? wb_result : rf_rs_data;
  assign sop     = iss_use_imm ? iss_imm : rs_data;

  mcpu_alu u_alu (
    .rt_data      (rt_data),
    .sop          (sop),
    .opcode       (iss_opcode),
    .compare_type (iss_compare_type),
    .shift_type   (iss_shift_type),
    .shift_amount (iss_shift_amount),
    .result       (alu_result),
    .alu_invalid  (alu_invalid)
  );

  // Writeback register
  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      wb_valid   <= 1'b0;
      wb_invalid <= 1'b0;
    end else begin
      wb_valid   <= iss_valid;
      wb_invalid <= iss_valid && alu_invalid;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (iss_valid) begin
      wb_rd_idx <= iss_rd_idx;
      wb_result <= alu_result;
    end
  end

  assign rf_we      = wb_valid && !wb_invalid;
  assign rf_wr_idx  = wb_rd_idx;
  assign rf_wr_data = wb_result;

endmodule

`default_nettype wire

// ==== mcpu_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_exec_top #(
  parameter int NUM_REGS = 32
) (
  input  logic                         clkrst_core_clk,
  input  logic                         reset,
  input  logic                         in_valid,
  input  mcpu_pkg::mcpu_reg_idx_t      in_rt_idx,
  input  mcpu_pkg::mcpu_reg_idx_t      in_rs_idx,
  input  mcpu_pkg::mcpu_reg_idx_t      in_rd_idx,
  input  logic                         in_use_imm,
  input  mcpu_pkg::mcpu_word_t         in_imm,
  input  mcpu_pkg::mcpu_opcode_t       in_opcode,
  input  mcpu_pkg::mcpu_compare_type_t in_compare_type,
  input  mcpu_pkg::mcpu_shift_type_t   in_shift_type,
  input  mcpu_pkg::mcpu_shift_amount_t in_shift_amount,
  output logic                         wb_valid,
  output mcpu_pkg::mcpu_reg_idx_t      wb_rd_idx,
  output mcpu_pkg::mcpu_word_t         wb_result,
  output logic                         wb_invalid
);

  import mcpu_pkg::*;

  mcpu_reg_idx_t rf_rt_idx;
  mcpu_reg_idx_t rf_rs_idx;
  mcpu_word_t    rf_rt_data;
  mcpu_word_t    rf_rs_data;
  logic          rf_we;
  mcpu_reg_idx_t rf_wr_idx;
  mcpu_word_t    rf_wr_data;

  mcpu_exec_stage #(
    .NUM_REGS (NUM_REGS)
  ) u_exec_stage (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .in_valid        (in_valid),
    .in_rt_idx       (in_rt_idx),
    .in_rs_idx       (in_rs_idx),
    .in_rd_idx       (in_rd_idx),
    .in_use_imm      (in_use_imm),
    .in_imm          (in_imm),
    .in_opcode       (in_opcode),
    .in_compare_type (in_compare_type),
    .in_shift_type   (in_shift_type),
    .in_shift_amount (in_shift_amount),
    .rf_rt_idx       (rf_rt_idx),
    .rf_rs_idx       (rf_rs_idx),
    .rf_rt_data      (rf_rt_data),
    .rf_rs_data      (rf_rs_data),
    .rf_we           (rf_we),
    .rf_wr_idx       (rf_wr_idx),
    .rf_wr_data      (rf_wr_data),
    .wb_valid        (wb_valid),
    .wb_rd_idx       (wb_rd_idx),
    .wb_result       (wb_result),
    .wb_invalid      (wb_invalid)
  );

  mcpu_regfile #(
    .NUM_REGS (NUM_REGS)
  ) u_regfile (
    .clkrst_core_clk (clkrst_core_clk),
    .reset           (reset),
    .rt_idx          (rf_rt_idx),
    .rs_idx          (rf_rs_idx),
    .rt_data         (rf_rt_data),
    .rs_data         (rf_rs_data),
    .we              (rf_we),
    .wr_idx          (rf_wr_idx),
    .wr_data         (rf_wr_data)
  );

endmodule

`default_nettype wire

// ==== mcpu_exec_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_exec_assertions (
  input wire logic                 clkrst_core_clk,
  input wire logic                 reset,
  input wire logic                 in_valid,
  input wire logic                 wb_valid,
  input wire mcpu_pkg::mcpu_word_t wb_result,
  input wire logic                 wb_invalid,
  input wire logic                 rf_we
);

  // X before the first reset edge counts as not high
  a_no_wb_in_reset: assert property (@(posedge clkrst_core_clk)
    reset |-> (wb_valid !== 1'b1))
    else $error("wb_valid high during reset");

  // Two-edge latency from issue strobe to result strobe
  a_wb_latency: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    wb_valid == $past(in_valid, 2))
    else $error("wb_valid does not follow in_valid by 2 edges");

  a_invalid_zero: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    wb_invalid |-> (wb_result == '0))
    else $error("wb_result nonzero on an invalid instruction");

  a_no_write_invalid: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    !(rf_we && wb_invalid))
    else $error("register write enabled for an invalid instruction");

endmodule

bind mcpu_exec_top mcpu_exec_assertions u_exec_assertions (
  .clkrst_core_clk (clkrst_core_clk),
  .reset           (reset),
  .in_valid        (in_valid),
  .wb_valid        (wb_valid),
  .wb_result       (wb_result),
  .wb_invalid      (wb_invalid),
  .rf_we           (rf_we)
);

`default_nettype wire

// ==== tb_mcpu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mcpu_exec;

  import mcpu_pkg::*;

  localparam int NUM_REGS = 24;
  // Test 4 issues a valid op, an invalid op and a read-back per step
  localparam int TOTAL_INSTR = 300 + 200 + 200 + 150 + 300;
  localparam int EDGE_LIMIT = 4 * TOTAL_INSTR + 100;

  logic               clk;
  logic               reset;
  logic               in_valid;
  mcpu_reg_idx_t      in_rt_idx;
  mcpu_reg_idx_t      in_rs_idx;
  mcpu_reg_idx_t      in_rd_idx;
  logic               in_use_imm;
  mcpu_word_t         in_imm;
  mcpu_opcode_t       in_opcode;
  mcpu_compare_type_t in_compare_type;
  mcpu_shift_type_t   in_shift_type;
  mcpu_shift_amount_t in_shift_amount;
  logic               wb_valid;
  mcpu_reg_idx_t      wb_rd_idx;
  mcpu_word_t         wb_result;
  logic               wb_invalid;

  mcpu_word_t    model_regs [32];
  mcpu_word_t    exp_result_q [$];
  mcpu_reg_idx_t exp_rd_q [$];
  logic          exp_invalid_q [$];
  int            exp_edge_q [$];
  logic [31:0]   rng_state;
  int            edge_cnt;
  int            err_count;
  int            err_mark;
  int            checked;
  int            tests_passed;
  int            tests_failed;
  mcpu_reg_idx_t last_rd0;
  mcpu_reg_idx_t last_rd1;

  mcpu_exec_top #(
    .NUM_REGS (NUM_REGS)
  ) u_mcpu_exec_top (
    .clkrst_core_clk (clk),
    .reset           (reset),
    .in_valid        (in_valid),
    .in_rt_idx       (in_rt_idx),
    .in_rs_idx       (in_rs_idx),
    .in_rd_idx       (in_rd_idx),
    .in_use_imm      (in_use_imm),
    .in_imm          (in_imm),
    .in_opcode       (in_opcode),
    .in_compare_type (in_compare_type),
    .in_shift_type   (in_shift_type),
    .in_shift_amount (in_shift_amount),
    .wb_valid        (wb_valid),
    .wb_rd_idx       (wb_rd_idx),
    .wb_result       (wb_result),
    .wb_invalid      (wb_invalid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // LCG, upper halves of two steps form one word
  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    hi = rng_state[31:16];
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {hi, rng_state[31:16]};
  endfunction

  function automatic int rand_below(input int n);
    return int'(rand32() % 32'(n));
  endfunction

  function automatic mcpu_word_t read_model(input mcpu_reg_idx_t idx);
    if (idx == 5'd0 || int'(idx) >= NUM_REGS) begin
      return '0;
    end
    return model_regs[idx];
  endfunction

  function automatic mcpu_word_t model_shift(input mcpu_word_t v, input logic [1:0] kind,
                                             input logic [5:0] amt);
    mcpu_word_t r;
    int n;
    n = int'(amt);
    r = v;
    case (kind)
      2'd0: r = (n >= 32) ? '0 : v << n;
      2'd1: r = (n >= 32) ? '0 : v >> n;
      2'd2: begin
        for (int i = 0; i < 32; i++) begin
          r[i] = (i + n < 32) ? v[i + n] : v[31];
        end
      end
      default: begin
        // 32 divides the modulus, so only amt[4:0] matters
        for (int i = 0; i < 32; i++) begin
          r[i] = v[(i + n) % 32];
        end
      end
    endcase
    return r;
  endfunction

  function automatic mcpu_word_t model_alu(input mcpu_word_t a, input mcpu_word_t b,
                                           input int op, input int cmp, output logic bad);
    logic [31:0] flip;
    flip = 32'h8000_0000;
    bad = 1'b0;
    case (op)
      0: return a + b;
      1: return a & b;
      2: return ~(a | b);
      3: return a | b;
      4: return b - a;
      5: return a - b;
      6: return a ^ b;
      8: return b;
      9: return ~b;
      10: return b[7] ? (b | 32'hFFFF_FF00) : (b & 32'h0000_00FF);
      11: return b[15] ? (b | 32'hFFFF_0000) : (b & 32'h0000_FFFF);
      7: begin
        case (cmp)
          0: return 32'(a < b);
          1: return 32'(a < b || a == b);
          2: return 32'(a == b);
          4: return 32'((a ^ flip) < (b ^ flip));
          5: return 32'((a ^ flip) <= (b ^ flip));
          6: return 32'((a & b) != 0);
          7: return 32'((a | b) == a);
          default: bad = 1'b1;
        endcase
      end
      default: bad = 1'b1;
    endcase
    return '0;
  endfunction

  task automatic flag_error(input string msg);
    err_count++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  task automatic issue_instr(input int rt, input int rs, input int rd, input logic use_imm,
                             input mcpu_word_t imm, input int op, input int cmp,
                             input int sht, input int sha);
    mcpu_word_t b;
    mcpu_word_t res;
    logic bad;
    while (rand_below(4) == 0) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
    @(posedge clk);
    in_valid        <= 1'b1;
    in_rt_idx       <= 5'(rt);
    in_rs_idx       <= 5'(rs);
    in_rd_idx       <= 5'(rd);
    in_use_imm      <= use_imm;
    in_imm          <= imm;
    in_opcode       <= 4'(op);
    in_compare_type <= 3'(cmp);
    in_shift_type   <= 2'(sht);
    in_shift_amount <= 6'(sha);
    b = model_shift(use_imm ? imm : read_model(5'(rs)), 2'(sht), 6'(sha));
    res = model_alu(read_model(5'(rt)), b, op, cmp, bad);
    if (!bad && rd != 0 && rd < NUM_REGS) begin
      model_regs[rd] = res;
    end
    exp_result_q.push_back(res);
    exp_rd_q.push_back(5'(rd));
    exp_invalid_q.push_back(bad);
    // Sampling edge is the next rising edge
    exp_edge_q.push_back(edge_cnt + 1);
    last_rd1 = last_rd0;
    last_rd0 = 5'(rd);
  endtask

  task automatic end_test(input string name);
    int errs;
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_result_q.size() != 0) begin
      @(posedge clk);
    end
    errs = err_count - err_mark;
    err_mark = err_count;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %s finished with %0d errors", name, errs);
  endtask

  function automatic int pick_src();
    case (rand_below(4))
      0: return int'(last_rd0);
      1: return int'(last_rd1);
      2: return (rand_below(3) == 0) ? 0 : 24 + rand_below(8);
      default: return rand_below(32);
    endcase
  endfunction

  // Outputs change on the rising edge and are sampled on the falling one
  always @(negedge clk) begin
    mcpu_word_t    e_res;
    mcpu_reg_idx_t e_rd;
    logic          e_inv;
    int            e_edge;
    edge_cnt = edge_cnt + 1;
    if (edge_cnt > EDGE_LIMIT) begin
      $display("Timeout: no finish within %0d clock cycles", EDGE_LIMIT);
      $display("TB FAILED");
      $finish;
    end else if (!reset && wb_valid) begin
      if (exp_result_q.size() == 0) begin
        err_count++;
        $display("Error at %0t: result came out with no instruction in flight", $time);
      end else begin
        e_res = exp_result_q.pop_front();
        e_rd = exp_rd_q.pop_front();
        e_inv = exp_invalid_q.pop_front();
        e_edge = exp_edge_q.pop_front();
        checked++;
        if (edge_cnt != e_edge + 2) begin
          err_count++;
          $display("Error at %0t: result did not arrive 2 edges after issue", $time);
        end
        if (wb_rd_idx != e_rd) begin
          flag_error($sformatf("wb_rd_idx %0d, expected %0d", wb_rd_idx, e_rd));
        end
        if (wb_invalid != e_inv) begin
          flag_error($sformatf("wb_invalid %0b, expected %0b", wb_invalid, e_inv));
        end
        if (wb_result != e_res) begin
          flag_error($sformatf("wb_result %08h, expected %08h", wb_result, e_res));
        end
      end
    end
  end

  initial begin
    int rt;
    int rd;
    int op;
    int sht;
    int sha;
    mcpu_word_t base;
    mcpu_word_t imm;
    reset = 1'b1;
    in_valid = 1'b0;
    in_rt_idx = '0;
    in_rs_idx = '0;
    in_rd_idx = '0;
    in_use_imm = 1'b0;
    in_imm = '0;
    in_opcode = '0;
    in_compare_type = '0;
    in_shift_type = '0;
    in_shift_amount = '0;
    rng_state = 32'd56;
    edge_cnt = 0;
    err_count = 0;
    err_mark = 0;
    checked = 0;
    tests_passed = 0;
    tests_failed = 0;
    last_rd0 = '0;
    last_rd1 = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < 300; i++) begin
      issue_instr(rand_below(24), rand_below(24), 1 + rand_below(23), rand_below(2) == 0,
                  rand32(), rand_below(7), rand_below(8), rand_below(4), rand_below(64));
    end
    end_test("arith_logic");

    for (int i = 0; i < 200; i++) begin
      sht = rand_below(4);
      sha = rand_below(64);
      if (i % 20 == 0) begin
        sht = int'(SH_ROR);
        sha = (i % 40 == 0) ? 0 : 32;
      end
      issue_instr(rand_below(24), rand_below(24), 1 + rand_below(23), rand_below(2) == 0,
                  rand32(), 8 + rand_below(2), 0, sht, sha);
    end
    end_test("shifter");

    for (int i = 0; i < 200; i++) begin
      rt = 1 + rand_below(23);
      base = read_model(5'(rt));
      case (rand_below(5))
        0: imm = base;
        1: imm = base + 32'd1;
        2: imm = base - 32'd1;
        3: imm = base ^ 32'h8000_0000;
        default: imm = rand32();
      endcase
      op = (rand_below(4) < 2) ? 7 : 10 + rand_below(2);
      issue_instr(rt, 0, 1 + rand_below(23), 1'b1, imm, op, rand_below(8), 0, 0);
    end
    end_test("sext_compare");

    for (int i = 0; i < 50; i++) begin
      rd = 1 + rand_below(23);
      issue_instr(rand_below(24), rand_below(24), 1 + rand_below(23), rand_below(2) == 0,
                  rand32(), rand_below(7), 0, 0, 0);
      issue_instr(rand_below(24), rand_below(24), rd, rand_below(2) == 0,
                  rand32(), 12 + rand_below(4), rand_below(8), rand_below(4), rand_below(64));
      // Read back the destination the invalid op must not have touched
      issue_instr(0, rd, 0, 1'b0, '0, int'(OP_MOV), 0, 0, 0);
    end
    end_test("invalid_ops");

    for (int i = 0; i < 300; i++) begin
      issue_instr(pick_src(), pick_src(), rand_below(32), rand_below(4) == 0, rand32(),
                  rand_below(12), rand_below(8), rand_below(4), rand_below(64));
    end
    end_test("deps_range");

    $display("Summary: %0d tests passed, %0d tests failed, %0d results checked, %0d errors",
             tests_passed, tests_failed, checked, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
mcpu_pkg.sv
mcpu_shifter.sv
mcpu_alu.sv
mcpu_regfile.sv
mcpu_exec_stage.sv
mcpu_exec_top.sv
mcpu_exec_assertions.sv
tb_mcpu_exec.sv
